//--- Makefile
# Verilator simulation of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tbRvCore
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass or fail from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+.
rvPkg.sv
rvDecoder.sv
rvRegFile.sv
rvAlu.sv
rvLoadStore.sv
rvControl.sv
rvCore.sv
tbMemory.sv
tbRvCore.sv

//--- rvAlu.sv
// ----------------------------------------
// RV32I ALU
// Adder, comparing subtractor, shared
// shifter, logic ops, branch predicate
// ----------------------------------------
module rvAlu (
   input  rvPkg::decoded_t decoded,
   input  rvPkg::word_t    rs1,
   input  rvPkg::word_t    rs2,
   output rvPkg::word_t    aluOut,
   output rvPkg::word_t    aluSum,      // Also the JALR target
   output logic            takeBranch
);

   rvPkg::word_t       op2;
   logic [32:0]        diff;
   logic               lt;
   logic               ltu;
   logic               eq;
   rvPkg::word_t       shiftSrc;
   logic signed [32:0] shiftIn;
   logic signed [32:0] shiftFull;
   rvPkg::word_t       shifted;

   // Bit reversal, turns the right shifter into a left shifter
   function automatic rvPkg::word_t flip(input rvPkg::word_t x);
      rvPkg::word_t y;
      for (int i = 0; i < 32; i++) y[i] = x[31-i];
      return y;
   endfunction

   // Register operand for R-type and branches, immediate otherwise
   assign op2 = (decoded.instrClass == rvPkg::ALU_REG ||
                 decoded.instrClass == rvPkg::BRANCH) ? rs2 : decoded.imm;

   assign aluSum = rs1 + op2;

   // One 33 bit subtract for SUB and every compare
   assign diff = {1'b0, rs1} - {1'b0, op2};
   assign ltu  = diff[32];                                   // Borrow out
   assign lt   = (rs1[31] ^ op2[31]) ? rs1[31] : diff[32];   // Signs differ
   assign eq   = (diff[31:0] == '0);

   // Sign fill only for SRA, left shifts go through flip on both sides
   assign shiftSrc  = (decoded.funct3 == 3'd1) ? flip(rs1) : rs1;
   assign shiftIn   = {decoded.arith & rs1[31], shiftSrc};
   assign shiftFull = shiftIn >>> op2[4:0];
   assign shifted   = shiftFull[31:0];

   always_comb begin
      case (decoded.funct3)
         3'd0:    aluOut = decoded.sub ? diff[31:0] : aluSum;  // ADD, SUB
         3'd1:    aluOut = flip(shifted);                      // SLL
         3'd2:    aluOut = {31'b0, lt};                        // SLT
         3'd3:    aluOut = {31'b0, ltu};                       // SLTU
         3'd4:    aluOut = rs1 ^ op2;
         3'd5:    aluOut = shifted;                            // SRL, SRA
         3'd6:    aluOut = rs1 | op2;
         default: aluOut = rs1 & op2;
      endcase
   end

   // Branch condition, control qualifies it with the class
   always_comb begin
      case (decoded.funct3)
         3'd0:    takeBranch = eq;     // BEQ
         3'd1:    takeBranch = !eq;    // BNE
         3'd4:    takeBranch = lt;     // BLT
         3'd5:    takeBranch = !lt;    // BGE
         3'd6:    takeBranch = ltu;    // BLTU
         3'd7:    takeBranch = !ltu;   // BGEU
         default: takeBranch = 1'b0;
      endcase
   end

endmodule

//--- rvControl.sv
// ----------------------------------------
// RV32I core control
// Four state FSM, program counter, next
// PC choice, write-back select and the
// memory bus strobes
// ----------------------------------------
`include "rvCore_settings.svh"

module rvControl (
   input  logic            clk,
   input  logic            reset,
   input  rvPkg::decoded_t decoded,
   input  rvPkg::word_t    aluOut,
   input  rvPkg::word_t    aluSum,
   input  logic            takeBranch,
   input  rvPkg::addr_t    lsAddr,
   input  rvPkg::word_t    loadData,
   input  rvPkg::word_t    storeData,
   input  rvPkg::wmask_t   storeMask,
   input  logic            memRbusy,
   input  logic            memWbusy,
   output logic            instrLoad,
   output logic            wbEnable,
   output rvPkg::word_t    wbData,
   output rvPkg::memReq_t  memReq
);

   localparam int           addrWidth = `RV_ADDR_WIDTH;
   localparam int           padWidth  = `RV_WORD_WIDTH - `RV_ADDR_WIDTH;
   localparam rvPkg::word_t resetAddr = `RV_RESET_ADDR;

   rvPkg::cpuState_t   state;
   rvPkg::addr_t       pc;
   rvPkg::addr_t       pcPlus4;
   rvPkg::addr_t       pcPlusImm;   // Branch and JAL target
   rvPkg::addr_t       nextPc;
   rvPkg::instrClass_t cls;
   logic               isLoad;
   logic               isStore;
   logic               memIdle;

   assign cls     = decoded.instrClass;
   assign isLoad  = (cls == rvPkg::LOAD);
   assign isStore = (cls == rvPkg::STORE);
   assign memIdle = !memRbusy && !memWbusy;

   assign pcPlus4   = pc + addrWidth'(4);
   assign pcPlusImm = pc + decoded.imm[addrWidth-1:0];

   always_comb begin
      if (cls == rvPkg::JALR)
         nextPc = {aluSum[addrWidth-1:1], 1'b0};             // Bit 0 cleared
      else if (cls == rvPkg::JAL || (cls == rvPkg::BRANCH && takeBranch))
         nextPc = pcPlusImm;
      else
         nextPc = pcPlus4;
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= rvPkg::WAIT_MEM;      // Wait for the bus to settle first
         pc    <= resetAddr[addrWidth-1:0];
      end else begin
         case (state)
            rvPkg::FETCH:      state <= rvPkg::WAIT_INSTR;
            rvPkg::WAIT_INSTR: if (!memRbusy) state <= rvPkg::EXECUTE;
            rvPkg::EXECUTE: begin
               pc    <= nextPc;
               state <= (isLoad || isStore) ? rvPkg::WAIT_MEM : rvPkg::FETCH;
            end
            default:           if (memIdle) state <= rvPkg::FETCH;  // WAIT_MEM
         endcase
      end
   end

   assign instrLoad = (state == rvPkg::WAIT_INSTR) && !memRbusy;

   // Non-memory results retire in EXECUTE, loads on leaving WAIT_MEM
   assign wbEnable = ((state == rvPkg::EXECUTE) &&
                      !(isLoad || isStore || cls == rvPkg::BRANCH || cls == rvPkg::OTHER)) ||
                     ((state == rvPkg::WAIT_MEM) && isLoad && memIdle);

   always_comb begin
      case (cls)
         rvPkg::LUI:               wbData = decoded.imm;
         rvPkg::AUIPC:             wbData = {{padWidth{1'b0}}, pc} + decoded.imm;  // Full word
         rvPkg::JAL, rvPkg::JALR:  wbData = {{padWidth{1'b0}}, pcPlus4};   // Link
         rvPkg::LOAD:              wbData = loadData;
         default:                  wbData = aluOut;
      endcase
   end

   // Fetch uses the PC, data accesses the load/store address
   always_comb begin
      if (state == rvPkg::FETCH || state == rvPkg::WAIT_INSTR)
         memReq.addr = {{padWidth{1'b0}}, pc};
      else
         memReq.addr = {{padWidth{1'b0}}, lsAddr};
      memReq.wdata = storeData;
      memReq.wmask = (state == rvPkg::EXECUTE && isStore) ? storeMask : '0;
      memReq.rstrb = (state == rvPkg::FETCH) || (state == rvPkg::EXECUTE && isLoad);
   end

endmodule

//--- rvCore.sv
// ----------------------------------------
// RV32I multicycle core top level
// Control FSM plus decoder, register
// bank, ALU and load/store datapath
// ----------------------------------------
module rvCore (
   input  logic           clk,
   input  logic           reset,
   input  rvPkg::word_t   memRdata,
   input  logic           memRbusy,
   input  logic           memWbusy,
   output rvPkg::memReq_t memReq
);

   logic            instrLoad;    // Fetched word valid, capture it
   rvPkg::decoded_t decoded;
   rvPkg::word_t    rs1;
   rvPkg::word_t    rs2;
   rvPkg::word_t    aluOut;
   rvPkg::word_t    aluSum;
   logic            takeBranch;
   rvPkg::addr_t    lsAddr;
   rvPkg::word_t    loadData;
   rvPkg::word_t    storeData;
   rvPkg::wmask_t   storeMask;
   logic            wbEnable;
   rvPkg::word_t    wbData;

   rvControl i_rvControl (
      .clk        (clk),
      .reset      (reset),
      .decoded    (decoded),
      .aluOut     (aluOut),
      .aluSum     (aluSum),
      .takeBranch (takeBranch),
      .lsAddr     (lsAddr),
      .loadData   (loadData),
      .storeData  (storeData),
      .storeMask  (storeMask),
      .memRbusy   (memRbusy),
      .memWbusy   (memWbusy),
      .instrLoad  (instrLoad),
      .wbEnable   (wbEnable),
      .wbData     (wbData),
      .memReq     (memReq)
   );

   rvDecoder i_rvDecoder (
      .clk       (clk),
      .reset     (reset),
      .instrLoad (instrLoad),
      .memRdata  (memRdata),
      .decoded   (decoded)
   );

   // Source indices come straight off the bus, same edge as the decoder
   rvRegFile i_rvRegFile (
      .clk       (clk),
      .instrLoad (instrLoad),
      .memRdata  (memRdata),
      .wbEnable  (wbEnable),
      .rd        (decoded.rd),
      .wbData    (wbData),
      .rs1       (rs1),
      .rs2       (rs2)
   );

   rvAlu i_rvAlu (
      .decoded    (decoded),
      .rs1        (rs1),
      .rs2        (rs2),
      .aluOut     (aluOut),
      .aluSum     (aluSum),
      .takeBranch (takeBranch)
   );

   rvLoadStore i_rvLoadStore (
      .decoded   (decoded),
      .rs1       (rs1),
      .rs2       (rs2),
      .memRdata  (memRdata),
      .lsAddr    (lsAddr),
      .loadData  (loadData),
      .storeData (storeData),
      .storeMask (storeMask)
   );

endmodule

//--- rvCore_settings.svh
// ----------------------------------------
// RV32I core build settings
// Bus address width, reset vector, data
// word width and integer register count
// ----------------------------------------
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Address bits driven by the core, upper bus bits stay zero
`define RV_ADDR_WIDTH 24

// First fetch address after reset
`define RV_RESET_ADDR 32'h0000_0000

`define RV_WORD_WIDTH 32  // Data word
`define RV_REG_COUNT  32  // Integer registers x0..x31

`endif

//--- rvDecoder.sv
// ----------------------------------------
// RV32I instruction decoder
// Holds the instruction register and
// derives class, fields and immediate
// ----------------------------------------
module rvDecoder (
   input  logic            clk,
   input  logic            reset,
   input  logic            instrLoad,   // Capture strobe from control
   input  rvPkg::word_t    memRdata,    // Fetched word
   output rvPkg::decoded_t decoded
);

   localparam rvPkg::word_t nopInstr = 32'h0000_0013;  // ADDI x0, x0, 0

   rvPkg::word_t       instr;        // Instruction register
   rvPkg::instrClass_t instrClass;
   rvPkg::word_t       immI;
   rvPkg::word_t       immS;
   rvPkg::word_t       immB;
   rvPkg::word_t       immU;
   rvPkg::word_t       immJ;

   // Cleared to a harmless NOP so nothing is written back before the first fetch
   always_ff @(posedge clk) begin
      if (!reset) begin
         instr <= nopInstr;
      end else if (instrLoad) begin
         instr <= memRdata;
      end
   end

   // Opcode classes, bits 1:0 are always 11 in the base set
   always_comb begin
      case (instr[6:0])
         7'b0000011: instrClass = rvPkg::LOAD;
         7'b0100011: instrClass = rvPkg::STORE;
         7'b0010011: instrClass = rvPkg::ALU_IMM;
         7'b0110011: instrClass = rvPkg::ALU_REG;
         7'b0110111: instrClass = rvPkg::LUI;
         7'b0010111: instrClass = rvPkg::AUIPC;
         7'b1100011: instrClass = rvPkg::BRANCH;
         7'b1101111: instrClass = rvPkg::JAL;
         7'b1100111: instrClass = rvPkg::JALR;
         default:    instrClass = rvPkg::OTHER;   // SYSTEM, FENCE, illegal
      endcase
   end

   // The five immediate formats
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      decoded.instrClass = instrClass;
      decoded.rd         = instr[11:7];
      decoded.funct3     = instr[14:12];
      // Bit 30 doubles as an immediate bit for ADDI, hence the class check
      decoded.sub        = (instrClass == rvPkg::ALU_REG) && instr[30];
      decoded.arith      = instr[30];     // SRA and SRAI
      case (instrClass)
         rvPkg::STORE:               decoded.imm = immS;
         rvPkg::BRANCH:              decoded.imm = immB;
         rvPkg::LUI, rvPkg::AUIPC:   decoded.imm = immU;
         rvPkg::JAL:                 decoded.imm = immJ;
         default:                    decoded.imm = immI;  // Loads, ALU_IMM, JALR
      endcase
   end

endmodule

//--- rvLoadStore.sv
// ----------------------------------------
// RV32I load/store unit
// Address adder, load lane select with
// extension, store replication and mask
// ----------------------------------------
`include "rvCore_settings.svh"

module rvLoadStore (
   input  rvPkg::decoded_t decoded,
   input  rvPkg::word_t    rs1,
   input  rvPkg::word_t    rs2,
   input  rvPkg::word_t    memRdata,
   output rvPkg::addr_t    lsAddr,
   output rvPkg::word_t    loadData,
   output rvPkg::word_t    storeData,
   output rvPkg::wmask_t   storeMask
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // Decoder already picked I or S immediate by class
   assign lsAddr = rs1[`RV_ADDR_WIDTH-1:0] + decoded.imm[`RV_ADDR_WIDTH-1:0];

   assign byteAccess = (decoded.funct3[1:0] == 2'b00);
   assign halfAccess = (decoded.funct3[1:0] == 2'b01);

   // Bus returns whole words, pick the lane from the low address bits
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !decoded.funct3[2] &                   // LBU, LHU zero fill
                     (byteAccess ? loadByte[7] : loadHalf[15]);

   always_comb begin
      if (byteAccess)      loadData = {{24{loadSign}}, loadByte};
      else if (halfAccess) loadData = {{16{loadSign}}, loadHalf};
      else                 loadData = memRdata;
   end

   // Low byte or halfword copied into every lane it can land in
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = lsAddr[0] ? rs2[7:0] :
                             lsAddr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << lsAddr[1:0];   // 0001 .. 1000
      end else if (halfAccess) begin
         storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

//--- rvPkg.sv
// ----------------------------------------
// RV32I core shared types
// Word and field types, instruction class
// and FSM enums, decoded instruction and
// memory request structs
// ----------------------------------------
`include "rvCore_settings.svh"

package rvPkg;

   typedef logic [`RV_WORD_WIDTH-1:0]          word_t;    // Data word
   typedef logic [`RV_ADDR_WIDTH-1:0]          addr_t;    // Byte address
   typedef logic [$clog2(`RV_REG_COUNT)-1:0]   regIdx_t;  // Register index
   typedef logic [2:0]                         funct3_t;  // Operation field
   typedef logic [3:0]                         wmask_t;   // Byte lane write mask

   // Instruction classes of the base set
   typedef enum logic [3:0] {
      LOAD,
      STORE,
      ALU_IMM,
      ALU_REG,
      LUI,
      AUIPC,
      BRANCH,
      JAL,
      JALR,
      OTHER     // SYSTEM, FENCE and anything unknown
   } instrClass_t;

   // Multicycle FSM
   typedef enum logic [1:0] {
      FETCH,
      WAIT_INSTR,
      EXECUTE,
      WAIT_MEM
   } cpuState_t;

   typedef struct packed {
      instrClass_t instrClass;
      regIdx_t     rd;
      funct3_t     funct3;
      logic        sub;       // Register form SUB only
      logic        arith;     // Sign fill on right shift
      word_t       imm;       // Immediate picked for the class
   } decoded_t;

   typedef struct packed {
      word_t  addr;
      word_t  wdata;
      wmask_t wmask;
      logic   rstrb;
   } memReq_t;

endpackage

//--- rvRegFile.sv
// ----------------------------------------
// RV32I integer register bank
// 32 x 32 bits, registered source reads,
// x0 reads as zero
// ----------------------------------------
`include "rvCore_settings.svh"

module rvRegFile (
   input  logic           clk,
   input  logic           instrLoad,   // Read strobe, same edge as the decoder
   input  rvPkg::word_t   memRdata,    // Fetched word, source fields used here
   input  logic           wbEnable,
   input  rvPkg::regIdx_t rd,
   input  rvPkg::word_t   wbData,
   output rvPkg::word_t   rs1,
   output rvPkg::word_t   rs2
);

   rvPkg::word_t   regs [`RV_REG_COUNT];
   rvPkg::regIdx_t rs1Idx;
   rvPkg::regIdx_t rs2Idx;

   assign rs1Idx = memRdata[19:15];
   assign rs2Idx = memRdata[24:20];

   always_ff @(posedge clk) begin
      if (wbEnable && rd != '0) regs[rd] <= wbData;   // Writes to x0 dropped
      if (instrLoad) begin
         rs1 <= (rs1Idx == '0) ? '0 : regs[rs1Idx];
         rs2 <= (rs2Idx == '0) ? '0 : regs[rs2Idx];
      end
   end

endmodule

//--- tbMemory.sv
// ----------------------------------------
// Testbench word memory
// 64 words, random busy delays from an
// LFSR, test loading port and a monitor
// that keeps the first store after reset
// ----------------------------------------
`include "rvCore_settings.svh"

module tbMemory (
   input  logic           clk,
   input  logic           reset,
   input  rvPkg::memReq_t memReq,
   output rvPkg::word_t   memRdata,
   output logic           memRbusy,
   output logic           memWbusy,
   input  logic           loadEn,      // Program and data loading
   input  logic [5:0]     loadIdx,
   input  rvPkg::word_t   loadWord,
   output logic           storeValid,  // Sticky, first store since reset
   output rvPkg::addr_t   storeAddr,
   output rvPkg::word_t   storeData,
   output rvPkg::wmask_t  storeMask
);
   timeunit 1ns;
   timeprecision 1ns;

   rvPkg::word_t mem [64];
   logic [7:0]   lfsr = 8'd71;   // Seed
   logic [7:0]   lfsrMid;
   logic [7:0]   lfsrNext;
   logic [1:0]   delay;          // Busy cycles for the next access
   logic [1:0]   rCount;
   logic [1:0]   wCount;
   logic [5:0]   idx;

   // Galois LFSR, taps for a maximal 8 bit sequence
   function automatic logic [7:0] lfsrStep(input logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
   endfunction

   // One step per bit taken, low bit out of each step
   assign lfsrMid  = lfsrStep(lfsr);
   assign lfsrNext = lfsrStep(lfsrMid);
   assign delay    = {lfsrMid[0], lfsr[0]};

   assign memRbusy = (rCount != 2'd0);
   assign memWbusy = (wCount != 2'd0);
   assign idx      = memReq.addr[7:2];   // Word index

   always @(posedge clk) begin
      if (loadEn) mem[loadIdx] <= loadWord;
      if (!reset) begin
         rCount     <= 2'd0;
         wCount     <= 2'd0;
         storeValid <= 1'b0;
      end else begin
         if (rCount != 2'd0) rCount <= rCount - 2'd1;
         if (wCount != 2'd0) wCount <= wCount - 2'd1;
         if (memReq.rstrb) begin
            memRdata <= mem[idx];   // Held until the next strobe
            rCount   <= delay;
            lfsr     <= lfsrNext;
         end
         if (memReq.wmask != 4'b0000) begin
            for (int b = 0; b < 4; b++)
               if (memReq.wmask[b]) mem[idx][8*b +: 8] <= memReq.wdata[8*b +: 8];
            wCount <= delay;
            lfsr   <= lfsrNext;
            $display("store addr %h data %h mask %b", memReq.addr, memReq.wdata, memReq.wmask);
            if (!storeValid) begin
               storeValid <= 1'b1;
               storeAddr  <= memReq.addr[`RV_ADDR_WIDTH-1:0];
               storeData  <= memReq.wdata;
               storeMask  <= memReq.wmask;
            end
         end
      end
   end

endmodule

//--- tbRvCore.sv
// ----------------------------------------
// RV32I core testbench
// Loads each table program, runs it to
// the first store and checks that store
// ----------------------------------------
module tbRvCore;
   timeunit 1ns;
   timeprecision 1ns;

   localparam int opLoad  = 'h03;
   localparam int opImm   = 'h13;
   localparam int opAuipc = 'h17;
   localparam int opLui   = 'h37;
   localparam int opJalr  = 'h67;
   localparam rvPkg::word_t nop = 32'h0000_0013;
   localparam rvPkg::word_t loadWordValue = 32'h80F7_1E92;   // Preloaded at 0x80

   logic clk = 1'b0;
   logic reset;
   rvPkg::word_t memRdata;
   logic memRbusy;
   logic memWbusy;
   rvPkg::memReq_t memReq;
   logic loadEn;
   logic [5:0] loadIdx;
   rvPkg::word_t loadWord;
   logic storeValid;
   rvPkg::addr_t storeAddr;
   rvPkg::word_t storeData;
   rvPkg::wmask_t storeMask;

   string         names [32];
   rvPkg::word_t  progs [32][8];
   rvPkg::word_t  datas [32];
   rvPkg::addr_t  expA [32];
   rvPkg::word_t  expD [32];
   rvPkg::wmask_t expM [32];
   int nTests = 0;
   int cycleLimit = 0;
   int runCycles = 0;
   logic running = 1'b0;

   always #50 clk = ~clk;   // 100 ns period

   rvCore i_rvCore (.clk(clk), .reset(reset), .memRdata(memRdata), .memRbusy(memRbusy),
                    .memWbusy(memWbusy), .memReq(memReq));

   tbMemory i_tbMemory (.clk(clk), .reset(reset), .memReq(memReq), .memRdata(memRdata),
                        .memRbusy(memRbusy), .memWbusy(memWbusy), .loadEn(loadEn),
                        .loadIdx(loadIdx), .loadWord(loadWord), .storeValid(storeValid),
                        .storeAddr(storeAddr), .storeData(storeData), .storeMask(storeMask));

   // RV32I encoders with the base ISA field layout
   function automatic rvPkg::word_t encR(input int f7, rs2, rs1, f3, rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
   endfunction
   function automatic rvPkg::word_t encI(input int imm, rs1, f3, rd, op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
   endfunction
   function automatic rvPkg::word_t encS(input int imm, rs2, rs1, f3);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
   endfunction
   function automatic rvPkg::word_t encB(input int imm, rs2, rs1, f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
   endfunction
   function automatic rvPkg::word_t encU(input int imm, rd, op);
      return {imm[19:0], rd[4:0], op[6:0]};
   endfunction
   function automatic rvPkg::word_t encJ(input int imm, rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
   endfunction

   task automatic addEntry(input string name, input rvPkg::word_t w0, w1, w2, w3, w4, w5, w6,
                           w7, input rvPkg::addr_t ea, input rvPkg::word_t ed,
                           input rvPkg::wmask_t em);
      names[nTests] = name;
      progs[nTests][0] = w0;
      progs[nTests][1] = w1;
      progs[nTests][2] = w2;
      progs[nTests][3] = w3;
      progs[nTests][4] = w4;
      progs[nTests][5] = w5;
      progs[nTests][6] = w6;
      progs[nTests][7] = w7;
      datas[nTests] = loadWordValue;
      expA[nTests] = ea;
      expD[nTests] = ed;
      expM[nTests] = em;
      nTests++;
   endtask

   // x1 = 0x12345678, x2 = -16, x4 = 4, op writes x3, SW x3 to 0x90
   task automatic aluTest(input string name, input rvPkg::word_t op, input rvPkg::word_t ed);
      addEntry(name, encU('h12345, 1, opLui), encI('h678, 1, 0, 1, opImm),
               encI(-16, 0, 0, 2, opImm), encI(4, 0, 0, 4, opImm), op,
               encS('h90, 3, 0, 2), nop, nop, 'h90, ed, 4'b1111);
   endtask

   // Taken branch skips the store of 0x11 at 0x90 and lands on 0x22 at 0x94
   task automatic branchTest(input string name, input int a, b, f3, input logic taken);
      addEntry(name, encI(a, 0, 0, 1, opImm), encI(b, 0, 0, 2, opImm), encB(12, 2, 1, f3),
               encI('h11, 0, 0, 3, opImm), encS('h90, 3, 0, 2), encI('h22, 0, 0, 3, opImm),
               encS('h94, 3, 0, 2), nop, taken ? 'h94 : 'h90, taken ? 'h22 : 'h11, 4'b1111);
   endtask

   task automatic storeTest(input string name, input rvPkg::word_t st, input rvPkg::addr_t ea,
                            input rvPkg::word_t ed, input rvPkg::wmask_t em);
      addEntry(name, encU('h12345, 1, opLui), encI('h678, 1, 0, 1, opImm), st,
               nop, nop, nop, nop, nop, ea, ed, em);
   endtask

   task automatic loadTest(input string name, input int off, f3, input rvPkg::word_t ed);
      addEntry(name, encI(off, 0, f3, 3, opLoad), encS('h90, 3, 0, 2), nop, nop, nop, nop,
               nop, nop, 'h90, ed, 4'b1111);
   endtask

   task automatic buildTable();
      aluTest("add", encR(0, 2, 1, 0, 3), 32'h1234_5668);
      aluTest("sub", encR('h20, 2, 1, 0, 3), 32'h1234_5688);
      aluTest("xor", encR(0, 2, 1, 4, 3), 32'hEDCB_A988);
      aluTest("or", encR(0, 2, 1, 6, 3), 32'hFFFF_FFF8);
      aluTest("and", encR(0, 2, 1, 7, 3), 32'h1234_5670);
      aluTest("sll", encR(0, 4, 1, 1, 3), 32'h2345_6780);
      aluTest("srl", encR(0, 4, 2, 5, 3), 32'h0FFF_FFFF);
      aluTest("sra", encR('h20, 4, 2, 5, 3), 32'hFFFF_FFFF);
      // slt(-16, x1) = 1, sltu(x1, 0xFFFFFFF0) = 1, combined as 1 | 1 << 4
      addEntry("slt_sltu", encU('h12345, 1, opLui), encI('h678, 1, 0, 1, opImm),
               encI(-16, 0, 0, 2, opImm), encR(0, 1, 2, 2, 3), encR(0, 2, 1, 3, 4),
               encI(4, 4, 1, 4, opImm), encR(0, 4, 3, 6, 3), encS('h90, 3, 0, 2),
               'h90, 32'h0000_0011, 4'b1111);
      addEntry("srai_xori", encU('h12345, 1, opLui), encI('h678, 1, 0, 1, opImm),
               encI(-16, 0, 0, 2, opImm), encI('h402, 2, 5, 3, opImm),
               encI(15, 3, 4, 3, opImm), encS('h90, 3, 0, 2), nop, nop,
               'h90, 32'hFFFF_FFF3, 4'b1111);
      branchTest("beq_taken", 5, 5, 0, 1'b1);
      branchTest("beq_not", 5, 6, 0, 1'b0);
      branchTest("blt_taken", -3, 5, 4, 1'b1);
      branchTest("blt_not", 5, -3, 4, 1'b0);
      addEntry("jal", nop, encJ(8, 1), encS('h94, 0, 0, 2), encS('h90, 1, 0, 2),
               nop, nop, nop, nop, 'h90, 32'h0000_0008, 4'b1111);
      addEntry("jalr", encI('h10, 0, 0, 2, opImm), encI(1, 2, 0, 1, opJalr),
               encS('h94, 0, 0, 2), encS('h94, 0, 0, 2), encS('h90, 1, 0, 2),
               nop, nop, nop, 'h90, 32'h0000_0008, 4'b1111);
      addEntry("auipc", nop, nop, encU('h12345, 3, opAuipc), encS('h90, 3, 0, 2),
               nop, nop, nop, nop, 'h90, 32'h1234_5008, 4'b1111);
      storeTest("sb_0", encS('h90, 1, 0, 0), 'h90, 32'h7878_7878, 4'b0001);
      storeTest("sb_1", encS('h91, 1, 0, 0), 'h91, 32'h7878_7878, 4'b0010);
      storeTest("sb_2", encS('h92, 1, 0, 0), 'h92, 32'h7878_7878, 4'b0100);
      storeTest("sb_3", encS('h93, 1, 0, 0), 'h93, 32'h7878_7878, 4'b1000);
      storeTest("sh_0", encS('h90, 1, 0, 1), 'h90, 32'h5678_5678, 4'b0011);
      storeTest("sh_2", encS('h92, 1, 0, 1), 'h92, 32'h5678_5678, 4'b1100);
      loadTest("lb_0", 'h80, 0, 32'hFFFF_FF92);
      loadTest("lbu_0", 'h80, 4, 32'h0000_0092);
      loadTest("lb_1", 'h81, 0, 32'h0000_001E);
      loadTest("lbu_3", 'h83, 4, 32'h0000_0080);
      loadTest("lh_0", 'h80, 1, 32'h0000_1E92);
      loadTest("lh_2", 'h82, 1, 32'hFFFF_80F7);
      loadTest("lhu_2", 'h82, 5, 32'h0000_80F7);
   endtask

   task automatic stopRun(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic checkAddr(input string name, input rvPkg::addr_t expected, actual);
      if (actual !== expected)
         stopRun($sformatf("Mismatch %s addr expected %h actual %h", name, expected, actual));
   endtask

   // Only the enabled byte lanes carry store data
   task automatic checkData(input string name, input rvPkg::word_t expected, actual,
                            input rvPkg::wmask_t lanes);
      rvPkg::word_t keep;
      keep = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
      if ((actual & keep) !== (expected & keep))
         stopRun($sformatf("Mismatch %s data expected %h actual %h", name, expected, actual));
   endtask

   task automatic checkMask(input string name, input rvPkg::wmask_t expected, actual);
      if (actual !== expected)
         stopRun($sformatf("Mismatch %s mask expected %b actual %b", name, expected, actual));
   endtask

   // Counts only the cycles in which a program runs
   always @(posedge clk) begin
      if (running) begin
         runCycles <= runCycles + 1;
         if (runCycles >= cycleLimit) stopRun("Timeout, the core made no store in time");
      end
   end

   task automatic runTest(input int t);
      @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < 64; i++) begin
         @(posedge clk);
         loadEn  <= 1'b1;
         loadIdx <= i[5:0];
         // Unused words are NOPs whose immediate is the word index
         loadWord <= (i < 8) ? progs[t][i] : (i == 32) ? datas[t] :
                     rvPkg::word_t'(32'h13 | (i << 20));
      end
      @(posedge clk);
      loadEn <= 1'b0;
      repeat (3) @(posedge clk);   // Reset held for 3 more cycles
      reset   <= 1'b1;
      running <= 1'b1;
      @(negedge clk);
      while (!storeValid) @(negedge clk);
      running <= 1'b0;
      checkAddr(names[t], expA[t], storeAddr);
      checkData(names[t], expD[t], storeData, expM[t]);
      checkMask(names[t], expM[t], storeMask);
   endtask

   initial begin
      reset    = 1'b0;
      loadEn   = 1'b0;
      loadIdx  = 6'd0;
      loadWord = '0;
      buildTable();
      cycleLimit = 40 * 8 * nTests;
      for (int t = 0; t < nTests; t++) runTest(t);
      $display("All tests passed");
      $finish;
   end

endmodule
